/* tb.f */
+incdir+.
zx_port_pkg.sv
zx_reg_pkg.sv
zx_port_decode.sv
zx_port_regs.sv
zx_port_readback.sv
zx_ports_top.sv
tb_zx_ports.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the port block testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --assert --timing --timescale 1ns/1ps \
	--top-module tb_zx_ports -f tb.f -o sim_zx_ports

./obj_dir/sim_zx_ports > sim.log
cat sim.log

if grep -q "tests failed" sim.log; then
	echo "simulation reported failures, see sim.log"
	exit 1
fi

echo "simulation finished without failures"
exit 0

/* tb_zx_ports.sv */
`timescale 1ns/1ps
`include "zx_defines.svh"

module tb_zx_ports;

	localparam int CLK_PERIOD = 8;
	localparam logic [1:0] OP_WR   = 2'd0;
	localparam logic [1:0] OP_RD   = 2'd1;
	localparam logic [1:0] OP_PEEK = 2'd2; // no bus cycle, look at outputs only

	typedef enum int {
		CHK_BORDER, CHK_PSD0, CHK_PSD1, CHK_PSD2, CHK_PSD3, CHK_P7FFD, CHK_PEFF7,
		CHK_VCFG, CHK_DOUT, CHK_DATAOUT, CHK_PORTHIT, CHK_BC1, CHK_BDIR
	} chk_t;

	logic                  clk;
	logic                  rst_n;
	logic [`ZX_ADDR_W-1:0] a;
	logic [`ZX_DATA_W-1:0] din;
	logic                  iorq_n;
	logic                  rd_n;
	logic                  wr_n;
	logic [4:0]            keys_in;
	logic [4:0]            kj_in;
	logic [7:0]            mus_in;
	logic [`ZX_DATA_W-1:0] dout;
	logic                  dataout;
	logic                  porthit;
	logic                  ay_bc1;
	logic                  ay_bdir;
	logic [5:0]            border;
	logic [`ZX_DATA_W-1:0] psd0;
	logic [`ZX_DATA_W-1:0] psd1;
	logic [`ZX_DATA_W-1:0] psd2;
	logic [`ZX_DATA_W-1:0] psd3;
	logic [`ZX_DATA_W-1:0] p7ffd;
	logic [`ZX_DATA_W-1:0] peff7;
	logic [`ZX_DATA_W-1:0] vcfg;

	// read path sampled while the strobes are low
	logic [7:0] rd_dout;
	logic       rd_dataout;
	logic       rd_porthit;
	logic       rd_bc1;
	logic       rd_bdir;

	string      tbl_name [64];
	logic [1:0] tbl_op   [64];
	logic [15:0] tbl_addr [64];
	logic [7:0] tbl_data [64];
	chk_t       tbl_chk  [64];
	logic [7:0] tbl_exp  [64];
	int         n_rows;
	int         errors;
	bit         timed_out;
	logic [31:0] rnd;
	logic [4:0] keys_v;
	logic [4:0] kj_v;
	logic [7:0] mus_v;

	zx_ports_top dut0 (
		.clk(clk), .rst_n(rst_n), .a(a), .din(din),
		.iorq_n(iorq_n), .rd_n(rd_n), .wr_n(wr_n),
		.keys_in(keys_in), .kj_in(kj_in), .mus_in(mus_in),
		.dout(dout), .dataout(dataout), .porthit(porthit),
		.ay_bc1(ay_bc1), .ay_bdir(ay_bdir), .border(border),
		.psd0(psd0), .psd1(psd1), .psd2(psd2), .psd3(psd3),
		.p7ffd(p7ffd), .peff7(peff7), .vcfg(vcfg)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	function automatic logic [7:0] observe(input chk_t c);
		logic [7:0] v;
		case (c)
			CHK_BORDER:  v = {2'b00, border};
			CHK_PSD0:    v = psd0;
			CHK_PSD1:    v = psd1;
			CHK_PSD2:    v = psd2;
			CHK_PSD3:    v = psd3;
			CHK_P7FFD:   v = p7ffd;
			CHK_PEFF7:   v = peff7;
			CHK_VCFG:    v = vcfg;
			CHK_DOUT:    v = rd_dout;
			CHK_DATAOUT: v = {7'b0, rd_dataout};
			CHK_PORTHIT: v = {7'b0, rd_porthit};
			CHK_BC1:     v = {7'b0, rd_bc1};
			default:     v = {7'b0, rd_bdir};
		endcase
		return v;
	endfunction

	task automatic add_row(input string name, input logic [1:0] op, input logic [15:0] addr,
		input logic [7:0] data, input chk_t chk, input logic [7:0] exp);
		tbl_name[n_rows] = name;
		tbl_op[n_rows]   = op;
		tbl_addr[n_rows] = addr;
		tbl_data[n_rows] = data;
		tbl_chk[n_rows]  = chk;
		tbl_exp[n_rows]  = exp;
		n_rows = n_rows + 1;
	endtask

	// n rising or falling edges, bounded in time
	task automatic wait_clk(input bit rising, input int n);
		int seen;
		int t0;
		seen = 0;
		t0 = int'($time);
		while (seen < n && !timed_out)
		begin
			if (rising)
				@(posedge clk);
			else
				@(negedge clk);
			seen = seen + 1;
			if (int'($time) - t0 > n * CLK_PERIOD)
			begin
				$display("timeout while waiting for %0d clock edges", n);
				timed_out = 1'b1;
			end
		end
	endtask

	task automatic bus_cycle(input logic [1:0] op, input logic [15:0] addr, input logic [7:0] data);
		wait_clk(1'b1, 1);
		a      <= addr;
		din    <= data;
		iorq_n <= 1'b0;
		if (op == OP_WR)
			wr_n <= 1'b0;
		else
			rd_n <= 1'b0;
		wait_clk(1'b0, 1);
		rd_dout    = dout;
		rd_dataout = dataout;
		rd_porthit = porthit;
		rd_bc1     = ay_bc1;
		rd_bdir    = ay_bdir;
		wait_clk(1'b1, 3); // strobes held for three edges
		iorq_n <= 1'b1;
		rd_n   <= 1'b1;
		wr_n   <= 1'b1;
		wait_clk(1'b1, 2);
	endtask

	task automatic check_row(input int i);
		logic [7:0] got;
		got = observe(tbl_chk[i]);
		assert (got === tbl_exp[i])
		else
		begin
			errors = errors + 1;
			$display("[FAIL] %s expected %h actual %h", tbl_name[i], tbl_exp[i], got);
		end
	endtask

	initial
	begin
		a = '0;
		din = '0;
		iorq_n = 1'b1;
		rd_n = 1'b1;
		wr_n = 1'b1;
		keys_in = '0;
		kj_in = '0;
		mus_in = '0;
		rst_n = 1'b0;
		n_rows = 0;
		errors = 0;
		timed_out = 1'b0;

		rnd = $urandom(37394);
		keys_v = rnd[4:0];
		rnd = $urandom();
		kj_v = rnd[4:0];
		rnd = $urandom();
		mus_v = rnd[7:0];

		wait_clk(1'b1, 1);
		keys_in <= keys_v;
		kj_in   <= kj_v;
		mus_in  <= mus_v;
		wait_clk(1'b1, 1);
		rst_n <= 1'b1;

		add_row("rst_p7ffd", OP_PEEK, 16'h0000, 8'h00, CHK_P7FFD, 8'h00);
		add_row("rst_peff7", OP_PEEK, 16'h0000, 8'h00, CHK_PEFF7, 8'h00);
		add_row("rst_vcfg", OP_PEEK, 16'h0000, 8'h00, CHK_VCFG, 8'h00);
		add_row("rst_border", OP_PEEK, 16'h0000, 8'h00, CHK_BORDER, 8'h00);
		add_row("rst_psd0", OP_PEEK, 16'h0000, 8'h00, CHK_PSD0, 8'h00);
		add_row("rst_psd1", OP_PEEK, 16'h0000, 8'h00, CHK_PSD1, 8'h00);
		add_row("rst_psd2", OP_PEEK, 16'h0000, 8'h00, CHK_PSD2, 8'h00);
		add_row("rst_psd3", OP_PEEK, 16'h0000, 8'h00, CHK_PSD3, 8'h00);
		add_row("rd_fe_keys", OP_RD, 16'h00FE, 8'h00, CHK_DOUT, {3'b100, keys_v});
		add_row("rd_fe_oe", OP_RD, 16'h00FE, 8'h00, CHK_DATAOUT, 8'h01);
		// beeper bit 4 set, every channel goes to all ones
		add_row("fe_border", OP_WR, 16'h00FE, 8'h17, CHK_BORDER, 8'h2A); // 1 0 1 0 1 0
		add_row("fe_psd0", OP_PEEK, 16'h0000, 8'h00, CHK_PSD0, 8'hFF);
		add_row("fe_psd1", OP_PEEK, 16'h0000, 8'h00, CHK_PSD1, 8'hFF);
		add_row("fe_psd2", OP_PEEK, 16'h0000, 8'h00, CHK_PSD2, 8'hFF);
		add_row("fe_psd3", OP_PEEK, 16'h0000, 8'h00, CHK_PSD3, 8'hFF);
		add_row("covox_psd0", OP_WR, 16'h00FB, 8'h5A, CHK_PSD0, 8'h5A);
		add_row("covox_psd1", OP_PEEK, 16'h0000, 8'h00, CHK_PSD1, 8'h5A);
		add_row("covox_psd2", OP_PEEK, 16'h0000, 8'h00, CHK_PSD2, 8'h5A);
		add_row("covox_psd3", OP_PEEK, 16'h0000, 8'h00, CHK_PSD3, 8'h5A);
		add_row("sd2_psd2", OP_WR, 16'h004F, 8'h33, CHK_PSD2, 8'h33);
		add_row("sd2_psd0", OP_PEEK, 16'h0000, 8'h00, CHK_PSD0, 8'h5A);
		add_row("sd2_psd1", OP_PEEK, 16'h0000, 8'h00, CHK_PSD1, 8'h5A);
		add_row("sd2_psd3", OP_PEEK, 16'h0000, 8'h00, CHK_PSD3, 8'h5A);
		// lock bit set first, then 1 MB mode turns it on
		add_row("pg_7ffd", OP_WR, 16'h7FFD, 8'h20, CHK_P7FFD, 8'h20);
		add_row("pg_eff7", OP_WR, 16'hEFF7, 8'h04, CHK_PEFF7, 8'h00); // block bit reads as zero
		add_row("pg_mask", OP_PEEK, 16'h0000, 8'h00, CHK_P7FFD, 8'h00);
		add_row("pg_locked", OP_WR, 16'h7FFD, 8'h07, CHK_P7FFD, 8'h00);
		add_row("pg_eff7_mask", OP_WR, 16'hEFF7, 8'hFF, CHK_PEFF7, 8'hB1);
		add_row("pg_eff7_clr", OP_WR, 16'hEFF7, 8'h00, CHK_PEFF7, 8'h00);
		add_row("pg_unmask", OP_PEEK, 16'h0000, 8'h00, CHK_P7FFD, 8'h20);
		add_row("xt_key", OP_WR, `ZX_XT_PORT, `ZX_XT_KEY, CHK_BORDER, 8'h2A);
		add_row("xt_addr0", OP_WR, `ZX_XT_PORT, 8'h00, CHK_BORDER, 8'h2A);
		add_row("xt_border", OP_WR, `ZX_XT_PORT, 8'h2D, CHK_BORDER, 8'h2D);
		add_row("xt_rd_border", OP_RD, 16'h00EF, 8'h00, CHK_DOUT, 8'h2D);
		add_row("xt_key2", OP_WR, `ZX_XT_PORT, `ZX_XT_KEY, CHK_VCFG, 8'h00);
		add_row("xt_addr8", OP_WR, `ZX_XT_PORT, 8'h08, CHK_VCFG, 8'h00);
		add_row("xt_vcfg", OP_WR, `ZX_XT_PORT, 8'h99, CHK_VCFG, 8'h99);
		add_row("xt_rd_vcfg", OP_RD, 16'h00EF, 8'h00, CHK_DOUT, 8'h99);
		// FE write in the middle must drop the sequence
		add_row("xt_key3", OP_WR, `ZX_XT_PORT, `ZX_XT_KEY, CHK_VCFG, 8'h99);
		add_row("xt_abort_fe", OP_WR, 16'h00FE, 8'h00, CHK_BORDER, 8'h00);
		add_row("xt_stray_addr", OP_WR, `ZX_XT_PORT, 8'h08, CHK_VCFG, 8'h99);
		add_row("xt_stray_data", OP_WR, `ZX_XT_PORT, 8'h44, CHK_VCFG, 8'h99);
		add_row("rd_joy", OP_RD, 16'h001F, 8'h00, CHK_DOUT, {3'b000, kj_v});
		add_row("rd_joy_oe", OP_RD, 16'h001F, 8'h00, CHK_DATAOUT, 8'h01);
		add_row("rd_mouse", OP_RD, 16'h00DF, 8'h00, CHK_DOUT, mus_v);
		add_row("rd_ay_oe", OP_RD, 16'hFFFD, 8'h00, CHK_DATAOUT, 8'h00);
		add_row("rd_ay_bc1", OP_RD, 16'hFFFD, 8'h00, CHK_BC1, 8'h01);
		add_row("rd_ay_bdir", OP_RD, 16'hFFFD, 8'h00, CHK_BDIR, 8'h00);
		add_row("wr_ay_bdir", OP_WR, 16'hBFFD, 8'h00, CHK_BDIR, 8'h01); // AY data write
		add_row("rd_unused", OP_RD, 16'h0000, 8'h00, CHK_DOUT, 8'hFF);
		add_row("rd_unused_hit", OP_RD, 16'h0000, 8'h00, CHK_PORTHIT, 8'h00);

		for (int i = 0; i < n_rows && !timed_out; i++)
		begin
			if (tbl_op[i] != OP_PEEK)
				bus_cycle(tbl_op[i], tbl_addr[i], tbl_data[i]);
			if (tbl_op[i] != OP_RD)
				wait_clk(1'b0, 1); // registers settled by the falling edge
			if (!timed_out)
				check_row(i);
		end

		$display("rows: %0d, errors: %0d, timeout: %0d", n_rows, errors, timed_out);
		if (errors == 0 && !timed_out)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

/* zx_ports_top.sv */
`timescale 1ns/1ps
`include "zx_defines.svh"

module zx_ports_top
	import zx_port_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic [`ZX_ADDR_W-1:0] a,
	input  logic [`ZX_DATA_W-1:0] din,
	input  logic                  iorq_n,
	input  logic                  rd_n,
	input  logic                  wr_n,
	input  logic [4:0]            keys_in,
	input  logic [4:0]            kj_in,
	input  logic [7:0]            mus_in,
	output logic [`ZX_DATA_W-1:0] dout,
	output logic                  dataout,
	output logic                  porthit,
	output logic                  ay_bc1,
	output logic                  ay_bdir,
	output logic [5:0]            border,
	output logic [`ZX_DATA_W-1:0] psd0,
	output logic [`ZX_DATA_W-1:0] psd1,
	output logic [`ZX_DATA_W-1:0] psd2,
	output logic [`ZX_DATA_W-1:0] psd3,
	output logic [`ZX_DATA_W-1:0] p7ffd,
	output logic [`ZX_DATA_W-1:0] peff7,
	output logic [`ZX_DATA_W-1:0] vcfg
);

	port_sel_t             sel;
	logic                  port_wr;
	logic [`ZX_DATA_W-1:0] xt_addr;

	zx_port_decode u_decode (
		.clk     (clk),
		.rst_n   (rst_n),
		.a       (a),
		.iorq_n  (iorq_n),
		.rd_n    (rd_n),
		.wr_n    (wr_n),
		.sel     (sel),
		.port_wr (port_wr),
		.porthit (porthit),
		.dataout (dataout),
		.ay_bc1  (ay_bc1),
		.ay_bdir (ay_bdir)
	);

	zx_port_regs u_regs (
		.clk     (clk),
		.rst_n   (rst_n),
		.sel     (sel),
		.port_wr (port_wr),
		.a       (a),
		.din     (din),
		.border  (border),
		.psd0    (psd0),
		.psd1    (psd1),
		.psd2    (psd2),
		.psd3    (psd3),
		.p7ffd   (p7ffd),
		.peff7   (peff7),
		.vcfg    (vcfg),
		.xt_addr (xt_addr)
	);

	zx_port_readback u_readback (
		.sel     (sel),
		.keys_in (keys_in),
		.kj_in   (kj_in),
		.mus_in  (mus_in),
		.border  (border),
		.vcfg    (vcfg),
		.xt_addr (xt_addr),
		.dout    (dout)
	);

endmodule

/* zx_port_readback.sv */
`timescale 1ns/1ps
`include "zx_defines.svh"

module zx_port_readback
	import zx_port_pkg::*;
(
	input  port_sel_t             sel,
	input  logic [4:0]            keys_in,
	input  logic [4:0]            kj_in,
	input  logic [7:0]            mus_in,
	input  logic [5:0]            border,
	input  logic [`ZX_DATA_W-1:0] vcfg,
	input  logic [`ZX_DATA_W-1:0] xt_addr,
	output logic [`ZX_DATA_W-1:0] dout
);

	logic [`ZX_DATA_W-1:0] xt_rdata;

	// indirect register selected by the last xt address write
	always_comb
	begin
		case (xt_addr)
			`ZX_XT_BORDER: xt_rdata = {2'b00, border};
			`ZX_XT_VCFG:   xt_rdata = vcfg;
			default:       xt_rdata = '1;
		endcase
	end

	always_comb
	begin
		case (sel)
			SEL_FE:      dout = {1'b1, 1'b0, 1'b0, keys_in}; // no tape input here
			SEL_SD1_JOY: dout = {3'b000, kj_in};             // kempston joystick
			SEL_MOUSE:   dout = mus_in;
			SEL_XT_READ: dout = xt_rdata;
			default:     dout = '1; // write-only and unused ports float high
		endcase
	end

endmodule

/* zx_port_regs.sv */
`timescale 1ns/1ps
`include "zx_defines.svh"

module zx_port_regs
	import zx_port_pkg::*, zx_reg_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  port_sel_t             sel,
	input  logic                  port_wr,
	input  logic [`ZX_ADDR_W-1:0] a,
	input  logic [`ZX_DATA_W-1:0] din,
	output logic [5:0]            border,
	output logic [`ZX_DATA_W-1:0] psd0,
	output logic [`ZX_DATA_W-1:0] psd1,
	output logic [`ZX_DATA_W-1:0] psd2,
	output logic [`ZX_DATA_W-1:0] psd3,
	output logic [`ZX_DATA_W-1:0] p7ffd,
	output logic [`ZX_DATA_W-1:0] peff7,
	output logic [`ZX_DATA_W-1:0] vcfg,
	output logic [`ZX_DATA_W-1:0] xt_addr
);

	logic [`ZX_DATA_W-1:0] p7ffd_int;
	logic [`ZX_DATA_W-1:0] peff7_int;
	logic block1m;
	logic block7ffd;
	logic xt_ctrl_wr;
	logic other_wr;
	xt_state_t xt_state;

	assign block1m   = peff7_int[PEFF7_BLOCK1M];
	assign block7ffd = p7ffd_int[P7FFD_LOCK] && block1m;

	// 55FF is matched on the full address
	assign xt_ctrl_wr = port_wr && (a == `ZX_XT_PORT);
	assign other_wr   = port_wr && !xt_ctrl_wr;

	// paging and config
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			p7ffd_int <= '0;
			peff7_int <= '0;
		end
		else if (port_wr)
		begin
			if (sel == SEL_7FFD && !block7ffd)
				p7ffd_int <= din; // 2..0 page, 3 screen, 4 rom, 5 lock
			if (sel == SEL_EFF7)
				peff7_int <= din;
		end
	end

	// upper page bits are hidden in 1 MB mode
	assign p7ffd = {block1m ? 3'b000 : p7ffd_int[7:5], p7ffd_int[P7FFD_ROM], p7ffd_int[3:0]};

	assign peff7 = block1m ? {peff7_int[7], 1'b0, peff7_int[5:4], 3'b000, peff7_int[0]}
	                       : peff7_int;

	// border, sound channels and xt registers
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			border   <= '0;
			psd0     <= '0;
			psd1     <= '0;
			psd2     <= '0;
			psd3     <= '0;
			vcfg     <= '0;
			xt_addr  <= '0;
			xt_state <= XT_LOCKED;
		end
		else
		begin
			if (other_wr)
			begin
				case (sel)
					SEL_FE:
					begin
						border <= {din[1], 1'b0, din[2], 1'b0, din[0], 1'b0};
						psd0   <= {`ZX_DATA_W{din[4]}}; // beeper on every channel
						psd1   <= {`ZX_DATA_W{din[4]}};
						psd2   <= {`ZX_DATA_W{din[4]}};
						psd3   <= {`ZX_DATA_W{din[4]}};
					end
					SEL_COVOX:
					begin
						psd0 <= din;
						psd1 <= din;
						psd2 <= din;
						psd3 <= din;
					end
					SEL_SD0:     psd0 <= din;
					SEL_SD1_JOY: psd1 <= din;
					SEL_SD2:     psd2 <= din;
					SEL_SD3:     psd3 <= din;
					default:     ;
				endcase
				xt_state <= XT_LOCKED; // any other port write aborts the sequence
			end

			if (xt_ctrl_wr)
			begin
				case (xt_state)
					XT_LOCKED:
					begin
						if (din == `ZX_XT_KEY)
							xt_state <= XT_ADDR;
					end
					XT_ADDR:
					begin
						xt_addr  <= din;
						xt_state <= XT_DATA;
					end
					XT_DATA:
					begin
						case (xt_addr)
							`ZX_XT_BORDER: border <= din[5:0];
							`ZX_XT_VCFG:   vcfg   <= din;
							default:       ;
						endcase
						xt_state <= XT_LOCKED;
					end
					default: xt_state <= XT_LOCKED;
				endcase
			end
		end
	end

endmodule

/* zx_port_decode.sv */
`timescale 1ns/1ps
`include "zx_defines.svh"

module zx_port_decode
	import zx_port_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic [`ZX_ADDR_W-1:0] a,
	input  logic                  iorq_n,
	input  logic                  rd_n,
	input  logic                  wr_n,
	output port_sel_t             sel,
	output logic                  port_wr,
	output logic                  porthit,
	output logic                  dataout,
	output logic                  ay_bc1,
	output logic                  ay_bdir
);

	logic [7:0] loa;
	logic io_wr;
	logic io_wr_d; // write strobe seen on the previous edge
	logic io_rd;
	logic ay_sel;

	assign loa   = a[7:0];
	assign io_wr = !iorq_n && !wr_n;
	assign io_rd = !iorq_n && !rd_n;

	// one pulse per bus write, on the first edge the strobe is low
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			io_wr_d <= 1'b0;
			port_wr <= 1'b0;
		end
		else
		begin
			io_wr_d <= io_wr;
			port_wr <= io_wr && !io_wr_d;
		end
	end

	always_comb
	begin
		sel = SEL_NONE;
		if (a == `ZX_XT_PORT) // checked first, low byte FF is otherwise unused
			sel = SEL_XT_CTRL;
		else
		begin
			case (loa)
				`ZX_PORT_FE: sel = SEL_FE;
				`ZX_PORT_FD:
				begin
					if (!a[15])
						sel = SEL_7FFD;
					else if (a[14])
						sel = SEL_AY_REG;
					else
						sel = SEL_AY_DATA;
				end
				`ZX_PORT_F7: sel = a[12] ? SEL_F7_OTHER : SEL_EFF7;
				`ZX_PORT_FB, `ZX_PORT_DD: sel = SEL_COVOX;
				`ZX_PORT_0F: sel = SEL_SD0;
				`ZX_PORT_1F: sel = SEL_SD1_JOY;
				`ZX_PORT_4F: sel = SEL_SD2;
				`ZX_PORT_5F: sel = SEL_SD3;
				`ZX_PORT_DF: sel = SEL_MOUSE;
				`ZX_PORT_EF: sel = SEL_XT_READ;
				default:     sel = SEL_NONE;
			endcase
		end
	end

	assign porthit = (sel != SEL_NONE);

	// AY chip drives the bus itself
	assign ay_sel  = (sel == SEL_AY_REG) || (sel == SEL_AY_DATA);
	assign dataout = porthit && io_rd && !ay_sel;

	// bc1 only for fffd, bdir for any AY write
	assign ay_bc1  = (sel == SEL_AY_REG) && !iorq_n && (!rd_n || !wr_n);
	assign ay_bdir = ay_sel && io_wr;

endmodule

/* zx_reg_pkg.sv */
package zx_reg_pkg;

	// bits of port 7ffd
	localparam int P7FFD_LOCK = 5; // 48k lock, honoured only with block1m
	localparam int P7FFD_ROM  = 4;

	// bits of port eff7
	localparam int PEFF7_BLOCK1M = 2;

	// state of the xt register access sequence on 55FF
	typedef enum logic [1:0] {
		XT_LOCKED, // waiting for the key byte
		XT_ADDR,   // next write is the register address
		XT_DATA    // next write goes to the addressed register
	} xt_state_t;

endpackage

/* zx_port_pkg.sv */
package zx_port_pkg;

	// decoded port of the current bus address
	typedef enum logic [3:0] {
		SEL_NONE,     // no internal port, bus left to the outside
		SEL_FE,       // border / beeper / keys
		SEL_7FFD,     // xxFD with a15 clear
		SEL_AY_REG,   // xxFD with a15:14 = 11, AY register select
		SEL_AY_DATA,  // xxFD with a15:14 = 10, AY data
		SEL_EFF7,     // xxF7 with a12 clear
		SEL_F7_OTHER, // rest of xxF7, reads as FF
		SEL_COVOX,    // FB or DD
		SEL_SD0,      // soundrive channel 0 at 0F
		SEL_SD1_JOY,  // 1F, channel 1 on write, joystick on read
		SEL_SD2,      // 4F
		SEL_SD3,      // 5F
		SEL_MOUSE,    // DF
		SEL_XT_READ,  // EF
		SEL_XT_CTRL   // full 55FF address
	} port_sel_t;

endpackage

/* zx_defines.svh */
`ifndef ZX_DEFINES_SVH
`define ZX_DEFINES_SVH

// z80 bus widths
`define ZX_ADDR_W      16
`define ZX_DATA_W      8

// low address byte of each decoded port
`define ZX_PORT_FE     8'hFE // border, beeper, keyboard
`define ZX_PORT_FD     8'hFD // 7ffd paging and AY
`define ZX_PORT_F7     8'hF7 // eff7 config
`define ZX_PORT_FB     8'hFB // covox
`define ZX_PORT_DD     8'hDD // covox, second address
`define ZX_PORT_0F     8'h0F // soundrive channels
`define ZX_PORT_1F     8'h1F // soundrive ch1 write, joystick read
`define ZX_PORT_4F     8'h4F
`define ZX_PORT_5F     8'h5F
`define ZX_PORT_DF     8'hDF // kempston mouse
`define ZX_PORT_EF     8'hEF // xt register read-back

// xt indirect register access
`define ZX_XT_PORT     16'h55FF
`define ZX_XT_KEY      8'hAA
`define ZX_XT_BORDER   8'h00
`define ZX_XT_VCFG     8'h08

`endif
